// File: icache_pkg.sv
package icache_pkg;

  //////////////////////////////
  // Cache geometry
  //////////////////////////////

  localparam int ADDR_WIDTH     = 32;
  localparam int WAYS_WIDTH     = 2;
  localparam int NUM_WAYS       = 4;
  localparam int SETS_WIDTH     = 4;
  localparam int NUM_SETS       = 16;
  localparam int WORD_IDX_WIDTH = 4;
  localparam int LINE_WORDS     = 16;
  // Everything above the set index and the 6 line offset bits
  localparam int TAG_WIDTH      = ADDR_WIDTH - SETS_WIDTH - 6;

  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [31:0]               word_t;
  typedef logic [TAG_WIDTH-1:0]      tag_bits_t;
  typedef logic [SETS_WIDTH-1:0]     set_idx_t;
  typedef logic [WORD_IDX_WIDTH-1:0] word_idx_t;
  typedef logic [WAYS_WIDTH-1:0]     way_idx_t;
  typedef logic [NUM_WAYS-1:0]       way_mask_t;

  //////////////////////////////
  // State machines
  //////////////////////////////

  typedef enum logic [1:0] {
    LOCK_NONE,
    LOCK_REFILL,
    LOCK_FETCH,
    LOCK_FLUSH
  } lock_holder_e;

  typedef enum logic [1:0] {
    REFILL_IDLE,
    REFILL_PROGRESS,
    REFILL_COMPLETE
  } refill_state_e;

  typedef enum logic [1:0] {
    FLUSH_RESET,
    FLUSH_IDLE,
    FLUSH_DONE
  } flush_state_e;

  typedef enum logic [2:0] {
    FETCH_IDLE,
    FETCH_LOOKUP,
    FETCH_REPLAY,
    FETCH_FILL,
    FETCH_EXC_WAIT,
    FETCH_EXC,
    FETCH_FLUSH
  } fetch_state_e;

endpackage

// File: icache_array_if.sv
interface icache_array_if (
  input logic clk_i
);

  // Lock handshake, pulses from the agent
  logic                   lock_acq;
  logic                   lock_rel;
  logic                   locking;
  logic                   locked;

  // Array write request
  logic                   wr_tag_req;
  logic                   wr_data_req;
  icache_pkg::way_mask_t  wr_ways;
  icache_pkg::set_idx_t   wr_set;
  icache_pkg::word_idx_t  wr_word;
  icache_pkg::tag_bits_t  wr_tag;
  logic                   wr_tag_valid;
  icache_pkg::word_t      wr_data;

  // Array read, only the fetch agent issues these
  logic                   rd_req;
  icache_pkg::set_idx_t   rd_set;
  icache_pkg::word_idx_t  rd_word;
  icache_pkg::tag_bits_t  rd_tags [icache_pkg::NUM_WAYS];
  icache_pkg::way_mask_t  rd_tag_valids;
  icache_pkg::word_t      rd_words [icache_pkg::NUM_WAYS];

  modport agent (
    output lock_acq, lock_rel, wr_tag_req, wr_data_req, wr_ways, wr_set, wr_word,
    output wr_tag, wr_tag_valid, wr_data, rd_req, rd_set, rd_word,
    input  locking, locked, rd_tags, rd_tag_valids, rd_words
  );

  modport arbiter (
    input  lock_acq, lock_rel, wr_tag_req, wr_data_req, wr_ways, wr_set, wr_word,
    input  wr_tag, wr_tag_valid, wr_data, rd_req, rd_set, rd_word,
    output locking, locked, rd_tags, rd_tag_valids, rd_words
  );

  // An agent only gives back a lock the arbiter has actually handed it
  a_rel_when_locked: assert property (@(posedge clk_i) lock_rel |-> locked);

endinterface

// File: icache_lock_arbiter.sv
module icache_lock_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  icache_array_if.arbiter       fetch_if,
  icache_array_if.arbiter       refill_if,
  icache_array_if.arbiter       flush_if,
  input  logic                  refill_move_i,
  // Array side
  output logic                  rd_req_o,
  output icache_pkg::set_idx_t  rd_set_o,
  output icache_pkg::word_idx_t rd_word_o,
  output logic                  wr_tag_req_o,
  output logic                  wr_data_req_o,
  output icache_pkg::way_mask_t wr_ways_o,
  output icache_pkg::set_idx_t  wr_set_o,
  output icache_pkg::word_idx_t wr_word_o,
  output icache_pkg::tag_bits_t wr_tag_o,
  output logic                  wr_tag_valid_o,
  output icache_pkg::word_t     wr_data_o,
  input  icache_pkg::tag_bits_t rd_tags_i [icache_pkg::NUM_WAYS],
  input  icache_pkg::way_mask_t rd_tag_valids_i,
  input  icache_pkg::word_t     rd_words_i [icache_pkg::NUM_WAYS]
);
  import icache_pkg::*;

  lock_holder_e holder_q, holder_d;
  logic refill_pend_q, refill_pend_d;
  logic flush_pend_q, flush_pend_d;
  logic fetch_pend_q, fetch_pend_d;

  //////////////////////////////
  // Lock ownership
  //////////////////////////////

  always_comb begin
    holder_d      = holder_q;
    refill_pend_d = refill_pend_q | refill_if.lock_acq;
    flush_pend_d  = flush_pend_q | flush_if.lock_acq;
    fetch_pend_d  = fetch_pend_q | fetch_if.lock_acq;

    if (refill_if.lock_rel || flush_if.lock_rel || fetch_if.lock_rel) begin
      holder_d = LOCK_NONE;
    end
    // Completed refill hands the array straight to fetch for the replay
    if (refill_move_i) begin
      holder_d = LOCK_FETCH;
    end

    if (holder_d == LOCK_NONE) begin
      if (refill_pend_d) begin
        holder_d      = LOCK_REFILL;
        refill_pend_d = 1'b0;
      end else if (flush_pend_d) begin
        holder_d     = LOCK_FLUSH;
        flush_pend_d = 1'b0;
      end else if (fetch_pend_d) begin
        holder_d     = LOCK_FETCH;
        fetch_pend_d = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      holder_q      <= LOCK_FLUSH;
      refill_pend_q <= 1'b0;
      flush_pend_q  <= 1'b0;
      fetch_pend_q  <= 1'b0;
    end else begin
      holder_q      <= holder_d;
      refill_pend_q <= refill_pend_d;
      flush_pend_q  <= flush_pend_d;
      fetch_pend_q  <= fetch_pend_d;
    end
  end

  assign refill_if.locking = holder_d == LOCK_REFILL;
  assign flush_if.locking  = holder_d == LOCK_FLUSH;
  assign fetch_if.locking  = holder_d == LOCK_FETCH;
  assign refill_if.locked  = holder_q == LOCK_REFILL;
  assign flush_if.locked   = holder_q == LOCK_FLUSH;
  assign fetch_if.locked   = holder_q == LOCK_FETCH;

  //////////////////////////////
  // Array multiplexing
  //////////////////////////////

  // Reads use the next holder so the data is ready in the first locked cycle
  assign rd_req_o  = fetch_if.rd_req && fetch_if.locking;
  assign rd_set_o  = fetch_if.rd_set;
  assign rd_word_o = fetch_if.rd_word;

  assign fetch_if.rd_tags        = rd_tags_i;
  assign fetch_if.rd_tag_valids  = rd_tag_valids_i;
  assign fetch_if.rd_words       = rd_words_i;
  assign refill_if.rd_tags       = '{default: '0};
  assign refill_if.rd_tag_valids = '0;
  assign refill_if.rd_words      = '{default: '0};
  assign flush_if.rd_tags        = '{default: '0};
  assign flush_if.rd_tag_valids  = '0;
  assign flush_if.rd_words       = '{default: '0};

  always_comb begin
    wr_tag_req_o   = 1'b0;
    wr_data_req_o  = 1'b0;
    wr_ways_o      = refill_if.wr_ways;
    wr_set_o       = refill_if.wr_set;
    wr_word_o      = refill_if.wr_word;
    wr_tag_o       = refill_if.wr_tag;
    wr_tag_valid_o = refill_if.wr_tag_valid;
    wr_data_o      = refill_if.wr_data;
    unique case (holder_q)
      LOCK_REFILL: begin
        wr_tag_req_o  = refill_if.wr_tag_req;
        wr_data_req_o = refill_if.wr_data_req;
      end
      LOCK_FLUSH: begin
        wr_tag_req_o   = flush_if.wr_tag_req;
        wr_data_req_o  = flush_if.wr_data_req;
        wr_ways_o      = flush_if.wr_ways;
        wr_set_o       = flush_if.wr_set;
        wr_word_o      = flush_if.wr_word;
        wr_tag_o       = flush_if.wr_tag;
        wr_tag_valid_o = flush_if.wr_tag_valid;
        wr_data_o      = flush_if.wr_data;
      end
      LOCK_FETCH: begin
        wr_tag_req_o   = fetch_if.wr_tag_req;
        wr_data_req_o  = fetch_if.wr_data_req;
        wr_ways_o      = fetch_if.wr_ways;
        wr_set_o       = fetch_if.wr_set;
        wr_word_o      = fetch_if.wr_word;
        wr_tag_o       = fetch_if.wr_tag;
        wr_tag_valid_o = fetch_if.wr_tag_valid;
        wr_data_o      = fetch_if.wr_data;
      end
      default: ;
    endcase
  end

  // The lock keeps agents from writing on top of each other
  a_one_writer: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({refill_if.wr_tag_req | refill_if.wr_data_req,
              flush_if.wr_tag_req | flush_if.wr_data_req,
              fetch_if.wr_tag_req | fetch_if.wr_data_req}));

endmodule

// File: icache_tag_array.sv
module icache_tag_array (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  rd_req_i,
  input  icache_pkg::set_idx_t  rd_set_i,
  input  icache_pkg::word_idx_t rd_word_i,
  input  logic                  wr_tag_req_i,
  input  logic                  wr_data_req_i,
  input  icache_pkg::way_mask_t wr_ways_i,
  input  icache_pkg::set_idx_t  wr_set_i,
  input  icache_pkg::word_idx_t wr_word_i,
  input  icache_pkg::tag_bits_t wr_tag_i,
  input  logic                  wr_tag_valid_i,
  input  icache_pkg::word_t     wr_data_i,
  output icache_pkg::tag_bits_t rd_tags_o [icache_pkg::NUM_WAYS],
  output icache_pkg::way_mask_t rd_tag_valids_o,
  output icache_pkg::word_t     rd_words_o [icache_pkg::NUM_WAYS]
);
  import icache_pkg::*;

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    tag_bits_t           tag_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_mem;
    word_t               data_mem [NUM_SETS*LINE_WORDS];

    tag_bits_t rd_tag_q;
    word_t     rd_word_q;
    logic      rd_valid_q;

    wire tag_we  = wr_tag_req_i && wr_ways_i[w];
    wire data_we = wr_data_req_i && wr_ways_i[w];

    always_ff @(posedge clk_i) begin
      if (tag_we) begin
        tag_mem[wr_set_i]   <= wr_tag_i;
        valid_mem[wr_set_i] <= wr_tag_valid_i;
      end
      if (data_we) begin
        data_mem[{wr_set_i, wr_word_i}] <= wr_data_i;
      end
      if (rd_req_i) begin
        rd_tag_q  <= tag_mem[rd_set_i];
        rd_word_q <= data_mem[{rd_set_i, rd_word_i}];
      end
    end

    // A stale valid out of reset would look like a hit
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rd_valid_q <= 1'b0;
      end else if (rd_req_i) begin
        rd_valid_q <= valid_mem[rd_set_i];
      end
    end

    assign rd_tags_o[w]       = rd_tag_q;
    assign rd_words_o[w]      = rd_word_q;
    assign rd_tag_valids_o[w] = rd_valid_q;
  end

endmodule

// File: icache_refill.sv
module icache_refill (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  icache_array_if.agent                      arr,
  input  icache_pkg::way_idx_t               fill_way_i,
  input  logic [icache_pkg::ADDR_WIDTH-7:0]  fill_line_i,
  input  logic                               mem_resp_valid_i,
  input  icache_pkg::word_t                  mem_resp_data_i,
  input  logic                               mem_resp_denied_i,
  output logic                               mem_resp_ready_o,
  output logic                               refill_move_o,
  output logic                               fill_last_o,
  output logic                               fill_denied_o
);
  import icache_pkg::*;

  refill_state_e state_q, state_d;
  word_idx_t     idx_q, idx_d;
  logic          denied_q, denied_d;

  wire beat = mem_resp_valid_i && mem_resp_ready_o;

  assign arr.lock_rel     = 1'b0;
  assign arr.rd_req       = 1'b0;
  assign arr.rd_set       = '0;
  assign arr.rd_word      = '0;
  assign arr.wr_ways      = way_mask_t'(1) << fill_way_i;
  assign arr.wr_set       = fill_line_i[SETS_WIDTH-1:0];
  assign arr.wr_word      = idx_q;
  assign arr.wr_tag       = fill_line_i[ADDR_WIDTH-7:SETS_WIDTH];
  assign arr.wr_tag_valid = 1'b1;
  assign arr.wr_data      = mem_resp_data_i;

  // Includes the beat in flight so the last beat's denial is seen in time
  assign fill_denied_o = denied_q || (beat && mem_resp_denied_i);

  always_comb begin
    state_d          = state_q;
    idx_d            = idx_q;
    denied_d         = denied_q;
    arr.lock_acq     = 1'b0;
    arr.wr_tag_req   = 1'b0;
    arr.wr_data_req  = 1'b0;
    mem_resp_ready_o = 1'b0;
    refill_move_o    = 1'b0;
    fill_last_o      = 1'b0;
    unique case (state_q)
      REFILL_IDLE: begin
        if (mem_resp_valid_i) begin
          arr.lock_acq = 1'b1;
          idx_d        = '0;
          denied_d     = 1'b0;
          state_d      = REFILL_PROGRESS;
        end
      end
      REFILL_PROGRESS: begin
        mem_resp_ready_o = arr.locked;
        arr.wr_data_req  = beat && !mem_resp_denied_i;
        arr.wr_tag_req   = beat && (&idx_q) && !mem_resp_denied_i;
        if (beat) begin
          idx_d    = idx_q + 1'b1;
          denied_d = fill_denied_o;
          if (&idx_q) begin
            fill_last_o = 1'b1;
            state_d     = REFILL_COMPLETE;
          end
        end
      end
      REFILL_COMPLETE: begin
        refill_move_o = 1'b1;
        state_d       = REFILL_IDLE;
      end
      default: state_d = REFILL_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= REFILL_IDLE;
      idx_q    <= '0;
      denied_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      idx_q    <= idx_d;
      denied_q <= denied_d;
    end
  end

endmodule

// File: icache_flush.sv
module icache_flush (
  input  logic          clk_i,
  input  logic          rst_ni,
  icache_array_if.agent arr,
  input  logic          flush_req_i,
  output logic          flush_done_o
);
  import icache_pkg::*;

  flush_state_e state_q, state_d;
  set_idx_t     idx_q;

  // Clear the valid bit of every way, one set per cycle
  assign arr.wr_tag_req   = state_q == FLUSH_RESET;
  assign arr.wr_ways      = '1;
  assign arr.wr_set       = idx_q;
  assign arr.wr_tag       = '0;
  assign arr.wr_tag_valid = 1'b0;
  assign arr.wr_data_req  = 1'b0;
  assign arr.wr_word      = '0;
  assign arr.wr_data      = '0;
  assign arr.rd_req       = 1'b0;
  assign arr.rd_set       = '0;
  assign arr.rd_word      = '0;

  assign arr.lock_acq = state_q == FLUSH_IDLE && flush_req_i;
  assign arr.lock_rel = state_q == FLUSH_RESET && (&idx_q);
  assign flush_done_o = state_q == FLUSH_DONE;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      FLUSH_RESET: if (&idx_q) state_d = FLUSH_DONE;
      FLUSH_IDLE:  if (arr.locking) state_d = FLUSH_RESET;
      FLUSH_DONE:  state_d = FLUSH_IDLE;
      default:     state_d = FLUSH_IDLE;
    endcase
  end

  // Out of reset the arbiter already hands the lock to this engine
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FLUSH_RESET;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == FLUSH_RESET) begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

endmodule

// File: icache_fetch_ctrl.sv
module icache_fetch_ctrl (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  icache_array_if.agent                      arr,
  input  logic                               req_valid_i,
  input  icache_pkg::addr_t                  req_pc_i,
  input  logic                               req_flush_i,
  output logic                               resp_valid_o,
  output icache_pkg::word_t                  resp_instr_o,
  output logic                               resp_exception_o,
  output logic                               mem_req_valid_o,
  output icache_pkg::addr_t                  mem_req_addr_o,
  input  logic                               mem_req_ready_i,
  output icache_pkg::way_idx_t               fill_way_o,
  output logic [icache_pkg::ADDR_WIDTH-7:0]  fill_line_o,
  input  logic                               fill_last_i,
  input  logic                               fill_denied_i,
  output logic                               flush_req_o,
  input  logic                               flush_done_i
);
  import icache_pkg::*;

  fetch_state_e state_q, state_d;
  addr_t        pc_q;
  way_idx_t     evict_q, evict_d;
  way_idx_t     way_q, way_d;
  logic         req_sent_q, req_sent_d;

  // New requests address the array directly, replays reuse the latched PC
  wire addr_t rd_pc = req_valid_i ? req_pc_i : pc_q;

  assign arr.rd_set       = rd_pc[SETS_WIDTH+5:6];
  assign arr.rd_word      = rd_pc[5:2];
  assign arr.wr_tag_req   = 1'b0;
  assign arr.wr_data_req  = 1'b0;
  assign arr.wr_ways      = '0;
  assign arr.wr_set       = '0;
  assign arr.wr_word      = '0;
  assign arr.wr_tag       = '0;
  assign arr.wr_tag_valid = 1'b0;
  assign arr.wr_data      = '0;

  assign mem_req_addr_o = {pc_q[ADDR_WIDTH-1:6], 6'd0};
  assign fill_line_o    = pc_q[ADDR_WIDTH-1:6];
  assign fill_way_o     = way_q;

  //////////////////////////////
  // Tag compare and victim
  //////////////////////////////

  way_mask_t hit;
  way_idx_t  hit_way;
  way_idx_t  victim;

  always_comb begin
    hit     = '0;
    hit_way = '0;
    victim  = evict_q;
    // Walk down so the lowest way wins both searches
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (arr.rd_tag_valids[w] && arr.rd_tags[w] == pc_q[ADDR_WIDTH-1:SETS_WIDTH+6]) begin
        hit[w]  = 1'b1;
        hit_way = way_idx_t'(w);
      end
      if (!arr.rd_tag_valids[w]) begin
        victim = way_idx_t'(w);
      end
    end
  end

  assign resp_instr_o     = arr.rd_words[hit_way];
  assign resp_exception_o = state_q == FETCH_EXC;

  //////////////////////////////
  // Main FSM
  //////////////////////////////

  always_comb begin
    state_d         = state_q;
    evict_d         = evict_q;
    way_d           = way_q;
    req_sent_d      = req_sent_q;
    arr.lock_acq    = 1'b0;
    arr.lock_rel    = 1'b0;
    arr.rd_req      = 1'b0;
    resp_valid_o    = 1'b0;
    mem_req_valid_o = 1'b0;
    flush_req_o     = 1'b0;
    unique case (state_q)
      FETCH_IDLE: ;
      FETCH_LOOKUP: begin
        arr.lock_rel = 1'b1;
        if (|hit) begin
          resp_valid_o = 1'b1;
          state_d      = FETCH_IDLE;
        end else begin
          way_d      = victim;
          evict_d    = evict_q + 1'b1;
          req_sent_d = 1'b0;
          state_d    = FETCH_FILL;
        end
      end
      FETCH_REPLAY: begin
        arr.rd_req = 1'b1;
        if (arr.locking) state_d = FETCH_LOOKUP;
      end
      FETCH_FILL: begin
        mem_req_valid_o = !req_sent_q;
        if (mem_req_ready_i) req_sent_d = 1'b1;
        // Refill passes the lock over on success, so only a fault needs it back
        if (fill_last_i) state_d = fill_denied_i ? FETCH_EXC_WAIT : FETCH_REPLAY;
      end
      FETCH_EXC_WAIT: begin
        if (arr.locked) begin
          arr.lock_rel = 1'b1;
          state_d      = FETCH_EXC;
        end
      end
      FETCH_EXC: begin
        resp_valid_o = 1'b1;
        state_d      = FETCH_IDLE;
      end
      FETCH_FLUSH: begin
        if (flush_done_i) begin
          arr.lock_acq = 1'b1;
          state_d      = FETCH_REPLAY;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase

    if (req_valid_i) begin
      if (req_flush_i) begin
        flush_req_o = 1'b1;
        state_d     = FETCH_FLUSH;
      end else begin
        arr.lock_acq = 1'b1;
        arr.rd_req   = 1'b1;
        state_d      = arr.locking ? FETCH_LOOKUP : FETCH_REPLAY;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= FETCH_IDLE;
      evict_q    <= '0;
      req_sent_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      evict_q    <= evict_d;
      req_sent_q <= req_sent_d;
    end
  end

  always_ff @(posedge clk_i) begin
    way_q <= way_d;
    if (req_valid_i) pc_q <= req_pc_i;
  end

  a_req_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> $stable(mem_req_addr_o));

endmodule

// File: icache_top.sv
module icache_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  // CPU side
  input  logic              req_valid_i,
  input  icache_pkg::addr_t req_pc_i,
  input  logic              req_flush_i,
  output logic              resp_valid_o,
  output icache_pkg::word_t resp_instr_o,
  output logic              resp_exception_o,
  // Memory side
  output logic              mem_req_valid_o,
  output icache_pkg::addr_t mem_req_addr_o,
  input  logic              mem_req_ready_i,
  input  logic              mem_resp_valid_i,
  input  icache_pkg::word_t mem_resp_data_i,
  input  logic              mem_resp_denied_i,
  output logic              mem_resp_ready_o
);
  import icache_pkg::*;

  icache_array_if fetch_if  (.clk_i(clk_i));
  icache_array_if refill_if (.clk_i(clk_i));
  icache_array_if flush_if  (.clk_i(clk_i));

  logic      rd_req, wr_tag_req, wr_data_req, wr_tag_valid;
  set_idx_t  rd_set, wr_set;
  word_idx_t rd_word, wr_word;
  way_mask_t wr_ways, rd_tag_valids;
  tag_bits_t wr_tag;
  word_t     wr_data;
  tag_bits_t rd_tags [NUM_WAYS];
  word_t     rd_words [NUM_WAYS];

  logic                  refill_move, fill_last, fill_denied;
  logic                  flush_req, flush_done;
  way_idx_t              fill_way;
  logic [ADDR_WIDTH-7:0] fill_line;

  icache_lock_arbiter u_arbiter (
    .clk_i, .rst_ni, .fetch_if, .refill_if, .flush_if,
    .refill_move_i   (refill_move),
    .rd_req_o        (rd_req),        .rd_set_o        (rd_set),
    .rd_word_o       (rd_word),       .wr_tag_req_o    (wr_tag_req),
    .wr_data_req_o   (wr_data_req),   .wr_ways_o       (wr_ways),
    .wr_set_o        (wr_set),        .wr_word_o       (wr_word),
    .wr_tag_o        (wr_tag),        .wr_tag_valid_o  (wr_tag_valid),
    .wr_data_o       (wr_data),       .rd_tags_i       (rd_tags),
    .rd_tag_valids_i (rd_tag_valids), .rd_words_i      (rd_words)
  );

  icache_tag_array u_array (
    .clk_i, .rst_ni,
    .rd_req_i        (rd_req),        .rd_set_i        (rd_set),
    .rd_word_i       (rd_word),       .wr_tag_req_i    (wr_tag_req),
    .wr_data_req_i   (wr_data_req),   .wr_ways_i       (wr_ways),
    .wr_set_i        (wr_set),        .wr_word_i       (wr_word),
    .wr_tag_i        (wr_tag),        .wr_tag_valid_i  (wr_tag_valid),
    .wr_data_i       (wr_data),       .rd_tags_o       (rd_tags),
    .rd_tag_valids_o (rd_tag_valids), .rd_words_o      (rd_words)
  );

  icache_refill u_refill (
    .clk_i, .rst_ni, .arr(refill_if),
    .fill_way_i    (fill_way),    .fill_line_i   (fill_line),
    .mem_resp_valid_i, .mem_resp_data_i, .mem_resp_denied_i, .mem_resp_ready_o,
    .refill_move_o (refill_move), .fill_last_o   (fill_last),
    .fill_denied_o (fill_denied)
  );

  icache_flush u_flush (
    .clk_i, .rst_ni, .arr(flush_if),
    .flush_req_i  (flush_req),
    .flush_done_o (flush_done)
  );

  icache_fetch_ctrl u_fetch (
    .clk_i, .rst_ni, .arr(fetch_if),
    .req_valid_i, .req_pc_i, .req_flush_i,
    .resp_valid_o, .resp_instr_o, .resp_exception_o,
    .mem_req_valid_o, .mem_req_addr_o, .mem_req_ready_i,
    .fill_way_o    (fill_way),    .fill_line_o   (fill_line),
    .fill_last_i   (fill_last),   .fill_denied_i (fill_denied),
    .flush_req_o   (flush_req),   .flush_done_i  (flush_done)
  );

endmodule

// File: tb_mem_model.sv
module tb_mem_model (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              mem_req_valid_i,
  input  icache_pkg::addr_t mem_req_addr_i,
  output logic              mem_req_ready_o,
  output logic              mem_resp_valid_o,
  output icache_pkg::word_t mem_resp_data_o,
  output logic              mem_resp_denied_o,
  input  logic              mem_resp_ready_i,
  output int                req_count_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import icache_pkg::*;

  localparam addr_t DENIED_BASE = 32'hF000_0000;
  localparam word_t DATA_MASK   = 32'hA5A5_0000;

  integer seed;

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  //////////////////////////////
  // Request and burst responder
  //////////////////////////////

  initial begin
    addr_t line_addr;
    addr_t word_addr;
    int    stall;
    seed              = 32'h2b8d97d0;
    mem_req_ready_o   = 1'b0;
    mem_resp_valid_o  = 1'b0;
    mem_resp_data_o   = '0;
    mem_resp_denied_o = 1'b0;
    req_count_o       = 0;
    wait (rst_ni === 1'b1);
    next_cycle();
    forever begin
      mem_req_ready_o = 1'b1;
      // Sampled mid-cycle, the transfer itself happens on the next rising edge
      do @(negedge clk_i); while (mem_req_valid_i !== 1'b1);
      line_addr   = mem_req_addr_i;
      req_count_o = req_count_o + 1;
      next_cycle();
      mem_req_ready_o = 1'b0;
      for (int i = 0; i < LINE_WORDS; i++) begin
        stall = {$random(seed)} % 4;
        repeat (stall) next_cycle();
        word_addr         = line_addr + addr_t'(4 * i);
        mem_resp_valid_o  = 1'b1;
        mem_resp_data_o   = word_addr ^ DATA_MASK;
        mem_resp_denied_o = word_addr >= DENIED_BASE;
        // Hold the beat until the refill engine owns the array
        do @(negedge clk_i); while (mem_resp_ready_i !== 1'b1);
        next_cycle();
        mem_resp_valid_o  = 1'b0;
        mem_resp_denied_o = 1'b0;
      end
    end
  end

endmodule

// File: tb_icache.sv
module tb_icache;
  timeunit 1ns;
  timeprecision 1ps;
  import icache_pkg::*;

  localparam int    HALF_PERIOD     = 10;
  localparam int    RESET_CYCLES    = 16;
  localparam int    CYCLES_PER_TEST = 400;
  localparam addr_t DENIED_BASE     = 32'hF000_0000;
  localparam word_t DATA_MASK       = 32'hA5A5_0000;

  typedef struct {
    string name;
    addr_t pc;
    logic  flush;
  } test_t;

  logic  clk_i;
  logic  rst_ni;
  logic  req_valid_i;
  addr_t req_pc_i;
  logic  req_flush_i;
  logic  resp_valid_o;
  word_t resp_instr_o;
  logic  resp_exception_o;
  logic  mem_req_valid_o;
  addr_t mem_req_addr_o;
  logic  mem_req_ready_i;
  logic  mem_resp_valid_i;
  word_t mem_resp_data_i;
  logic  mem_resp_denied_i;
  logic  mem_resp_ready_o;
  int    req_count;

  test_t     tests [$];
  tag_bits_t ref_tag   [NUM_SETS][NUM_WAYS];
  logic      ref_valid [NUM_SETS][NUM_WAYS];
  way_idx_t  ref_evict;
  int        error_count;
  int        pass_count;
  int        fail_count;

  icache_top dut (
    .clk_i, .rst_ni,
    .req_valid_i, .req_pc_i, .req_flush_i,
    .resp_valid_o, .resp_instr_o, .resp_exception_o,
    .mem_req_valid_o, .mem_req_addr_o, .mem_req_ready_i,
    .mem_resp_valid_i, .mem_resp_data_i, .mem_resp_denied_i, .mem_resp_ready_o
  );

  tb_mem_model u_mem (
    .clk_i, .rst_ni,
    .mem_req_valid_i   (mem_req_valid_o),
    .mem_req_addr_i    (mem_req_addr_o),
    .mem_req_ready_o   (mem_req_ready_i),
    .mem_resp_valid_o  (mem_resp_valid_i),
    .mem_resp_data_o   (mem_resp_data_i),
    .mem_resp_denied_o (mem_resp_denied_i),
    .mem_resp_ready_i  (mem_resp_ready_o),
    .req_count_o       (req_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #HALF_PERIOD clk_i = ~clk_i;
  end

  function automatic void add_test(string name, addr_t pc, logic flush);
    test_t t;
    t.name  = name;
    t.pc    = pc;
    t.flush = flush;
    tests.push_back(t);
  endfunction

  // Set 3 lines are 0x400 apart, five of them overflow the four ways
  function automatic void load_table();
    add_test("first_miss",     32'h0000_1004, 1'b0);
    add_test("line_hit",       32'h0000_1008, 1'b0);
    add_test("word_hit",       32'h0000_1004, 1'b0);
    add_test("denied_miss",    32'hF000_0040, 1'b0);
    add_test("denied_retry",   32'hF000_0044, 1'b0);
    add_test("set3_way_a",     32'h2000_00C0, 1'b0);
    add_test("set3_way_b",     32'h2000_04C4, 1'b0);
    add_test("set3_way_c",     32'h2000_08C8, 1'b0);
    add_test("set3_way_d",     32'h2000_0CCC, 1'b0);
    add_test("set3_evict",     32'h2000_10D0, 1'b0);
    add_test("refetch_a",      32'h2000_00C0, 1'b0);
    add_test("refetch_b",      32'h2000_04C4, 1'b0);
    add_test("refetch_c",      32'h2000_08C8, 1'b0);
    add_test("refetch_d",      32'h2000_0CCC, 1'b0);
    add_test("refetch_e",      32'h2000_10D0, 1'b0);
    add_test("flush_request",  32'h0000_3010, 1'b1);
    add_test("after_flush",    32'h0000_1004, 1'b0);
    add_test("flush_line_hit", 32'h0000_3014, 1'b0);
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Returns 1 when the access has to go to memory
  function automatic logic model_access(addr_t pc, logic flush);
    set_idx_t  set_idx;
    tag_bits_t tag;
    way_idx_t  victim;
    logic      hit;
    logic      found;
    if (flush) begin
      foreach (ref_valid[s, w]) ref_valid[s][w] = 1'b0;
    end
    set_idx = pc[SETS_WIDTH+5:6];
    tag     = pc[ADDR_WIDTH-1:SETS_WIDTH+6];
    hit     = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (ref_valid[set_idx][w] && ref_tag[set_idx][w] == tag) hit = 1'b1;
    end
    if (hit) return 1'b0;
    // Lowest invalid way first, round robin otherwise
    victim = ref_evict;
    found  = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!found && !ref_valid[set_idx][w]) begin
        victim = way_idx_t'(w);
        found  = 1'b1;
      end
    end
    ref_evict = ref_evict + 2'd1;
    if (pc < DENIED_BASE) begin
      ref_valid[set_idx][victim] = 1'b1;
      ref_tag[set_idx][victim]   = tag;
    end
    return 1'b1;
  endfunction

  function automatic word_t expected_word(addr_t pc);
    return {pc[ADDR_WIDTH-1:2], 2'b00} ^ DATA_MASK;
  endfunction

  // First byte of the 64-byte line that holds pc
  function automatic addr_t line_address(addr_t pc);
    return pc & ~addr_t'(LINE_WORDS * 4 - 1);
  endfunction

  //////////////////////////////
  // Checks and stimulus
  //////////////////////////////

  task automatic word_check(string test, string what, word_t exp, word_t act);
    if (act !== exp) begin
      $display("ERROR %s: %s expected %h actual %h", test, what, exp, act);
      error_count++;
    end
  endtask

  task automatic addr_check(string test, string what, addr_t exp, addr_t act);
    if (act !== exp) begin
      $display("ERROR %s: %s expected %h actual %h", test, what, exp, act);
      error_count++;
    end
  endtask

  task automatic flag_check(string test, string what, logic exp, logic act);
    if (act !== exp) begin
      $display("ERROR %s: %s expected %b actual %b", test, what, exp, act);
      error_count++;
    end
  endtask

  task automatic count_check(string test, string what, int exp, int act);
    if (act != exp) begin
      $display("ERROR %s: %s expected %0d actual %0d", test, what, exp, act);
      error_count++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic run_test(test_t t);
    logic  expect_miss;
    logic  expect_denied;
    int    count_before;
    int    errors_before;
    int    latency;
    logic  got_resp;
    word_t got_instr;
    logic  got_exc;
    expect_denied = t.pc >= DENIED_BASE;
    expect_miss   = model_access(t.pc, t.flush);
    count_before  = req_count;
    errors_before = error_count;
    latency       = 0;
    got_resp      = 1'b0;
    got_instr     = '0;
    got_exc       = 1'b0;
    req_valid_i   = 1'b1;
    req_pc_i      = t.pc;
    req_flush_i   = t.flush;
    while (got_resp !== 1'b1) begin
      next_cycle();
      req_valid_i = 1'b0;
      req_flush_i = 1'b0;
      latency++;
      @(negedge clk_i);
      if (mem_req_valid_o === 1'b1) begin
        addr_check(t.name, "memory request address", line_address(t.pc), mem_req_addr_o);
      end
      got_resp  = resp_valid_o;
      got_instr = resp_instr_o;
      got_exc   = resp_exception_o;
    end
    count_check(t.name, "memory requests", expect_miss ? 1 : 0, req_count - count_before);
    flag_check(t.name, "exception", expect_denied, got_exc);
    if (!expect_denied) begin
      word_check(t.name, "instruction", expected_word(t.pc), got_instr);
    end
    // The lock is always free between entries, so a hit takes one cycle
    if (!expect_miss && !t.flush) begin
      count_check(t.name, "hit latency", 1, latency);
    end
    if (error_count == errors_before) begin
      pass_count++;
      $display("PASS %s pc %h after %0d cycles", t.name, t.pc, latency);
    end else begin
      fail_count++;
      $display("FAIL %s pc %h after %0d cycles", t.name, t.pc, latency);
    end
  endtask

  initial begin
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_pc_i    = '0;
    req_flush_i = 1'b0;
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    ref_evict   = '0;
    foreach (ref_valid[s, w]) begin
      ref_valid[s][w] = 1'b0;
      ref_tag[s][w]   = '0;
    end
    load_table();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    // The first entry goes in while the reset flush still owns the array
    foreach (tests[i]) begin
      next_cycle();
      run_test(tests[i]);
    end
    $display("Summary: %0d of %0d entries passed, %0d failed, %0d mismatches",
             pass_count, tests.size(), fail_count, error_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    @(posedge rst_ni);
    repeat ((tests.size() + 1) * CYCLES_PER_TEST) @(posedge clk_i);
    $display("Timeout: the cache gave no response within %0d cycles",
             (tests.size() + 1) * CYCLES_PER_TEST);
    $display("test failed");
    $finish;
  end

endmodule

// File: all.f
icache_pkg.sv
icache_array_if.sv
icache_lock_arbiter.sv
icache_tag_array.sv
icache_refill.sv
icache_flush.sv
icache_fetch_ctrl.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_icache
FILELIST = all.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
